//--- Makefile
TOP := fa_cache_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f fa_cache.f -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- fa_cache.f
verilog/cache_geom_pkg.sv
verilog/cache_ctrl_pkg.sv
verilog/data_ram_if.sv
verilog/tag_cam.sv
verilog/data_ram.sv
verilog/cache_controller.sv
verilog/perf_counters.sv
verilog/fa_cache_top.sv
verification/fa_cache_assertions.sv
verification/fa_cache_tb.sv

//--- verification/fa_cache_assertions.sv
`timescale 1ns/1ps

module fa_cache_assertions (
	input logic                       clock_bus_i,
	input logic                       resetn_i,
	input logic                       done_i,
	input logic                       mem_req_i,
	input logic                       mem_we_i,
	input cache_geom_pkg::word_addr_t mem_addr_i,
	input cache_geom_pkg::word_t      mem_wdata_i,
	input logic                       mem_ack_i
);

	// ------------------------------------------------------------
	// core and memory handshake rules
	// ------------------------------------------------------------
	done_single_cycle: assert property (@(posedge clock_bus_i) disable iff (!resetn_i)
		done_i |=> !done_i)
		else $error("done_o stayed high for more than one cycle");

	// request and its fields hold until the ack edge
	mem_req_stable: assert property (@(posedge clock_bus_i) disable iff (!resetn_i)
		mem_req_i && !mem_ack_i |=> mem_req_i && $stable(mem_we_i)
			&& $stable(mem_addr_i) && $stable(mem_wdata_i))
		else $error("memory request changed before mem_ack_i");

	done_not_during_mem: assert property (@(posedge clock_bus_i) disable iff (!resetn_i)
		!(done_i && mem_req_i))
		else $error("done_o raised while a memory request was open");

endmodule

bind cache_controller fa_cache_assertions fa_cache_assertions_inst (
	.clock_bus_i (clock_bus_i),
	.resetn_i    (resetn_i),
	.done_i      (done_o),
	.mem_req_i   (mem_req_o),
	.mem_we_i    (mem_we_o),
	.mem_addr_i  (mem_addr_o),
	.mem_wdata_i (mem_wdata_o),
	.mem_ack_i   (mem_ack_i)
);

//--- verification/fa_cache_tb.sv
`timescale 1ns/1ps

module fa_cache_tb;
	import cache_geom_pkg::*;
	import cache_ctrl_pkg::*;

	typedef struct {
		string      name;
		logic       rw;                             // 1 write, 0 read
		word_addr_t addr;
		word_t      wdata;
		logic       exp_hit;
		logic       exp_wb;                         // miss evicts a dirty block
	} row_t;

	logic       clock_bus;
	logic       resetn;
	logic       req;
	logic       rw;
	word_addr_t addr;
	word_t      wdata;
	logic       done;
	logic       hit;
	word_t      rdata;
	logic       mem_req;
	logic       mem_we;
	word_addr_t mem_addr;
	word_t      mem_wdata;
	logic       mem_ack;
	word_t      mem_rdata;
	logic [1:0] metric_sel;
	count_t     count;

	row_t        rows [$];
	word_t       backing [1 << bw_addr_lp];         // memory model, also the reference
	word_t       shadow [word_addr_t];              // last value written per address
	logic [31:0] lfsr_state = 32'hec5d_a1b4;
	int          mem_writes = 0;                    // write transactions seen
	int          cycles = 0;

	fa_cache_top fa_cache_top_inst (
		.clock_bus_i  (clock_bus),
		.resetn_i     (resetn),
		.req_i        (req),
		.rw_i         (rw),
		.addr_i       (addr),
		.wdata_i      (wdata),
		.done_o       (done),
		.hit_o        (hit),
		.rdata_o      (rdata),
		.mem_req_o    (mem_req),
		.mem_we_o     (mem_we),
		.mem_addr_o   (mem_addr),
		.mem_wdata_o  (mem_wdata),
		.mem_ack_i    (mem_ack),
		.mem_rdata_i  (mem_rdata),
		.metric_sel_i (metric_sel),
		.count_o      (count)
	);

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	function automatic word_t pattern_of(input word_addr_t a);
		return {16'h0000, a} ^ 32'hc3a5_5a3c;           // fill value before any write
	endfunction

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic int unsigned lfsr_bits(input int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic add_row(input string name, input logic is_wr, input word_addr_t a,
		input word_t d, input logic exp_hit, input logic exp_wb);
		row_t r;
		r.name    = name;
		r.rw      = is_wr;
		r.addr    = a;
		r.wdata   = d;
		r.exp_hit = exp_hit;
		r.exp_wb  = exp_wb;
		rows.push_back(r);
	endtask

	task automatic report_mismatch(input string test, input word_t expected, input word_t actual);
		$display("[ERROR] %s: expected %h, actual %h", test, expected, actual);
		$display("Checks failed");
		$fatal(1, "stopped at first mismatch");
	endtask

	// one core request, held until done
	task automatic apply_row(input row_t r);
		word_t expected;
		expected = shadow.exists(r.addr) ? shadow[r.addr] : pattern_of(r.addr);
		@(posedge clock_bus);
		#1;
		req   = 1'b1;
		rw    = r.rw;
		addr  = r.addr;
		wdata = r.wdata;
		do begin
			@(posedge clock_bus);
			#1;                                         // done, hit, rdata settled
		end while (done !== 1'b1);
		assert (hit === r.exp_hit)
			else report_mismatch({r.name, " hit"}, word_t'(r.exp_hit), word_t'(hit));
		if (r.rw) begin
			shadow[r.addr] = r.wdata;
		end else begin
			assert (rdata === expected) else report_mismatch(r.name, expected, rdata);
		end
		req = 1'b0;                                     // at least one idle cycle follows
	endtask

	task automatic check_metric(input metric_sel_t sel, input string test, input int expected);
		@(posedge clock_bus);
		#1;
		metric_sel = sel;
		@(posedge clock_bus);
		#1;
		assert (count === count_t'(expected))
			else report_mismatch(test, word_t'(expected), word_t'(count));
	endtask

	// ------------------------------------------------------------
	// clock, memory model, watchdog
	// ------------------------------------------------------------
	initial begin
		clock_bus = 1'b0;
		forever #4 clock_bus = ~clock_bus;              // 8 ns period
	end

	initial begin : memory_model
		int unsigned delay;
		mem_ack   = 1'b0;
		mem_rdata = '0;
		forever begin
			@(posedge clock_bus);
			#1;
			mem_ack = 1'b0;                             // ack lasts one edge
			if (mem_req) begin
				delay = lfsr_bits(2);                   // 0 to 3 wait cycles
				repeat (delay) begin
					@(posedge clock_bus);
					#1;
				end
				if (mem_we) begin
					backing[mem_addr] = mem_wdata;
					mem_writes++;
				end else begin
					mem_rdata = backing[mem_addr];
				end
				mem_ack = 1'b1;
			end
		end
	end

	initial begin : watchdog
		do begin
			@(posedge clock_bus);
			cycles++;
		end while (cycles <= 40 * rows.size());
		$display("timeout, the cache stopped answering after %0d cycles", cycles);
		$display("Checks failed");
		$fatal(1, "timeout");
	end

	// ------------------------------------------------------------
	// stimulus table and final checks
	// ------------------------------------------------------------
	initial begin : stimulus
		int exp_hits;
		int exp_misses;
		int exp_wbs;
		resetn     = 1'b0;
		req        = 1'b0;
		rw         = 1'b0;
		addr       = '0;
		wdata      = '0;
		metric_sel = none;
		for (int a = 0; a < (1 << bw_addr_lp); a++) begin
			backing[a] = pattern_of(word_addr_t'(a));
		end
		// name               rw    addr      wdata         hit   wb
		add_row("rd_miss_first",    1'b0, 16'h0010, 32'h0,        1'b0, 1'b0);
		add_row("rd_hit_word1",     1'b0, 16'h0011, 32'h0,        1'b1, 1'b0);
		add_row("rd_hit_word3",     1'b0, 16'h0013, 32'h0,        1'b1, 1'b0);
		add_row("wr_hit",           1'b1, 16'h0012, 32'h1111_2222, 1'b1, 1'b0);
		add_row("rd_after_wr",      1'b0, 16'h0012, 32'h0,        1'b1, 1'b0);
		add_row("wr_miss_alloc",    1'b1, 16'h0124, 32'hdead_beef, 1'b0, 1'b0);
		add_row("rd_after_wr_miss", 1'b0, 16'h0124, 32'h0,        1'b1, 1'b0);
		add_row("fill_slot2",       1'b0, 16'h0200, 32'h0,        1'b0, 1'b0);
		add_row("fill_slot3",       1'b0, 16'h0300, 32'h0,        1'b0, 1'b0);
		add_row("fill_slot4",       1'b0, 16'h0400, 32'h0,        1'b0, 1'b0);
		add_row("fill_slot5",       1'b0, 16'h0500, 32'h0,        1'b0, 1'b0);
		add_row("fill_slot6",       1'b0, 16'h0600, 32'h0,        1'b0, 1'b0);
		add_row("fill_slot7",       1'b0, 16'h0700, 32'h0,        1'b0, 1'b0);
		add_row("evict_first",      1'b0, 16'h0800, 32'h0,        1'b0, 1'b1);  // slot 0 dirty
		add_row("reread_evicted",   1'b0, 16'h0012, 32'h0,        1'b0, 1'b1);  // slot 1 dirty
		add_row("hit_late_slot7",   1'b0, 16'h0701, 32'h0,        1'b1, 1'b0);
		add_row("hit_late_slot2",   1'b0, 16'h0203, 32'h0,        1'b1, 1'b0);
		add_row("reread_wb_block",  1'b0, 16'h0124, 32'h0,        1'b0, 1'b0);  // slot 2 clean
		add_row("wr_hit_slot3",     1'b1, 16'h0302, 32'h5566_7788, 1'b1, 1'b0);
		add_row("evict_slot3",      1'b0, 16'h0900, 32'h0,        1'b0, 1'b1);
		add_row("reread_slot3_wr",  1'b0, 16'h0302, 32'h0,        1'b0, 1'b0);  // slot 4 clean
		exp_hits = 0;
		exp_wbs  = 0;
		foreach (rows[i]) begin
			if (rows[i].exp_hit) begin
				exp_hits++;
			end
			if (rows[i].exp_wb) begin
				exp_wbs++;
			end
		end
		exp_misses = rows.size() - exp_hits;

		repeat (2) @(posedge clock_bus);
		#1;
		resetn = 1'b1;
		foreach (rows[i]) begin
			apply_row(rows[i]);
		end

		// every written word went out through a write-back
		foreach (shadow[a]) begin
			assert (backing[a] === shadow[a])
				else report_mismatch("writeback_backing", shadow[a], backing[a]);
		end
		assert (mem_writes == 4 * exp_wbs)
			else report_mismatch("writeback_words", word_t'(4 * exp_wbs), word_t'(mem_writes));
		check_metric(hits, "count_hits", exp_hits);
		check_metric(misses, "count_misses", exp_misses);
		check_metric(writebacks, "count_writebacks", exp_wbs);
		check_metric(none, "count_none", 0);

		$display("All checks passed");
		$finish;
	end

endmodule

//--- verilog/cache_controller.sv
`timescale 1ns/1ps

module cache_controller (
	input  logic                       clock_bus_i,
	input  logic                       resetn_i,
	// core side
	input  logic                       req_i,
	input  logic                       rw_i,             // 1 write, 0 read
	input  cache_geom_pkg::word_addr_t addr_i,
	input  cache_geom_pkg::word_t      wdata_i,
	output logic                       done_o,           // one cycle pulse
	output logic                       hit_o,
	output cache_geom_pkg::word_t      rdata_o,
	// tag cam
	output cache_geom_pkg::tag_t       lookup_tag_o,
	input  logic                       cam_hit_i,
	input  cache_geom_pkg::slot_t      cam_slot_i,
	output logic                       cam_wr_o,
	output cache_geom_pkg::slot_t      cam_slot_o,       // victim slot, read and write
	output cache_geom_pkg::tag_t       cam_tag_o,
	input  cache_geom_pkg::tag_t       cam_victim_tag_i,
	// data ram
	data_ram_if.ctrl                   ram,
	// backing memory, one word per transaction
	output logic                       mem_req_o,
	output logic                       mem_we_o,
	output cache_geom_pkg::word_addr_t mem_addr_o,
	output cache_geom_pkg::word_t      mem_wdata_o,
	input  logic                       mem_ack_i,
	input  cache_geom_pkg::word_t      mem_rdata_i,
	// perf flags
	output logic                       flag_hit_o,
	output logic                       flag_miss_o,
	output logic                       flag_wb_o
);
	import cache_geom_pkg::*;
	import cache_ctrl_pkg::*;

	ctrl_state_t            state;
	logic                   rw_r;
	word_addr_t             addr_r;
	word_t                  wdata_r;
	logic                   miss_r;             // request missed, hit_o stays low
	slot_t                  victim_ptr;         // fifo replacement pointer
	offset_t                cnt;                // next word to issue
	logic [capacity_lp-1:0] dirty;
	tag_t                   req_tag;
	offset_t                req_off;
	logic                   mem_xfer;
	logic                   last_word;

	assign req_tag   = addr_r[bw_addr_lp-1:bw_block_lp];
	assign req_off   = addr_r[bw_block_lp-1:0];
	assign mem_xfer  = mem_req_o & mem_ack_i;               // transaction ends this edge
	assign last_word = (mem_addr_o[bw_block_lp-1:0] == offset_t'(block_words_lp - 1));

	assign lookup_tag_o = req_tag;
	assign cam_slot_o   = victim_ptr;
	assign cam_tag_o    = req_tag;
	assign cam_wr_o     = (state == fill_read) && mem_xfer && last_word;

	// flags, lookup lasts one cycle so each is a single pulse
	assign flag_hit_o  = (state == lookup) && cam_hit_i && !miss_r;
	assign flag_miss_o = (state == lookup) && !cam_hit_i;
	assign flag_wb_o   = flag_miss_o && dirty[victim_ptr];   // dirty implies valid

	// ------------------------------------------------------------
	// data ram port
	// ------------------------------------------------------------
	always_comb begin
		ram.addr  = {victim_ptr, cnt};                  // write-back prefetch
		ram.wdata = wdata_r;
		ram.wren  = 1'b0;
		case (state)
			lookup: begin
				if (cam_hit_i) begin
					ram.addr = {cam_slot_i, req_off};       // hit access
					ram.wren = rw_r;
				end
			end
			fill_read: begin
				ram.addr  = {victim_ptr, mem_addr_o[bw_block_lp-1:0]};
				ram.wdata = mem_rdata_i;
				ram.wren  = mem_xfer;                   // word lands with ack
			end
			default: begin
			end
		endcase
	end

	// ------------------------------------------------------------
	// control state
	// ------------------------------------------------------------
	always_ff @(posedge clock_bus_i) begin
		if (!resetn_i) begin
			state      <= idle;
			done_o     <= 1'b0;
			hit_o      <= 1'b0;
			mem_req_o  <= 1'b0;
			mem_we_o   <= 1'b0;
			miss_r     <= 1'b0;
			cnt        <= '0;
			dirty      <= '0;
			victim_ptr <= '0;
		end else begin
			case (state)
				idle: begin
					done_o <= 1'b0;
					// done_o high means the old request is still on the port
					if (req_i && !done_o) begin
						miss_r <= 1'b0;
						cnt    <= '0;
						state  <= lookup;
					end
				end
				lookup: begin
					if (cam_hit_i) begin
						if (rw_r) begin
							dirty[cam_slot_i] <= 1'b1;
						end
						state <= respond;
					end else begin
						miss_r <= 1'b1;
						state  <= dirty[victim_ptr] ? wb_write : fill_read;
					end
				end
				wb_write: begin
					if (!mem_req_o) begin
						mem_req_o <= 1'b1;              // word cnt is on ram.rdata now
						mem_we_o  <= 1'b1;
						cnt       <= cnt + offset_t'(1);
					end else if (mem_ack_i) begin
						mem_req_o <= 1'b0;
						if (last_word) begin
							state <= fill_read;             // cnt has wrapped to 0
						end
					end
				end
				fill_read: begin
					if (!mem_req_o) begin
						mem_req_o <= 1'b1;
						mem_we_o  <= 1'b0;
						cnt       <= cnt + offset_t'(1);
					end else if (mem_ack_i) begin
						mem_req_o <= 1'b0;
						if (last_word) begin
							dirty[victim_ptr] <= 1'b0;      // fresh block
							victim_ptr        <= victim_ptr + slot_t'(1);
							state             <= lookup;    // redo access, now a hit
						end
					end
				end
				respond: begin
					done_o <= 1'b1;
					hit_o  <= !miss_r;
					state  <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	// ------------------------------------------------------------
	// payload registers
	// ------------------------------------------------------------
	always_ff @(posedge clock_bus_i) begin
		if (state == idle && req_i && !done_o) begin
			rw_r    <= rw_i;
			addr_r  <= addr_i;
			wdata_r <= wdata_i;
		end
		if (state == wb_write && !mem_req_o) begin
			mem_addr_o  <= {cam_victim_tag_i, cnt};     // victim tag stays put until fill end
			mem_wdata_o <= ram.rdata;
		end
		if (state == fill_read && !mem_req_o) begin
			mem_addr_o <= {req_tag, cnt};
		end
		if (state == respond) begin
			rdata_o <= ram.rdata;                       // read issued in lookup
		end
	end

endmodule

//--- verilog/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

	// ------------------------------------------------------------
	// controller fsm
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		idle,                   // waiting for a core request
		lookup,                 // tag compare, hit access into data ram
		wb_write,               // dirty victim out, one word per mem transaction
		fill_read,              // block in from backing memory
		respond                 // capture read data, pulse done
	} ctrl_state_t;

	// ------------------------------------------------------------
	// performance metric select
	// ------------------------------------------------------------
	typedef enum logic [1:0] {
		hits       = 2'd0,
		misses     = 2'd1,
		writebacks = 2'd2,      // dirty evictions
		none       = 2'd3       // reads as zero
	} metric_sel_t;

endpackage

//--- verilog/cache_geom_pkg.sv
package cache_geom_pkg;

	// ------------------------------------------------------------
	// block geometry
	// ------------------------------------------------------------
	localparam int block_words_lp = 4;                         // words per block
	localparam int bw_block_lp    = 2;                         // word offset bits
	localparam int capacity_lp    = 8;                         // blocks in the cache
	localparam int bw_slot_lp     = 3;                         // slot index bits

	// ------------------------------------------------------------
	// address split
	// ------------------------------------------------------------
	localparam int bw_addr_lp = 16;                            // word address, not byte
	localparam int bw_tag_lp  = bw_addr_lp - bw_block_lp;      // [tag|offset]

	// vectors with a meaning of their own
	typedef logic [31:0]             word_t;                   // one data word
	typedef logic [bw_addr_lp-1:0]   word_addr_t;
	typedef logic [bw_tag_lp-1:0]    tag_t;
	typedef logic [bw_slot_lp-1:0]   slot_t;                   // block slot in data ram
	typedef logic [bw_block_lp-1:0]  offset_t;                 // word within a block

	// data ram address is [slot|offset]
	typedef logic [bw_slot_lp+bw_block_lp-1:0] ram_addr_t;

	typedef logic [15:0]             count_t;                  // perf counter value

endpackage

//--- verilog/data_ram.sv
`timescale 1ns/1ps

module data_ram (
	input  logic clock_bus_i,
	data_ram_if.ram ram                             // addr, wdata, wren in, rdata out
);
	import cache_geom_pkg::*;

	// one word per [slot|offset]
	word_t mem [capacity_lp * block_words_lp];

	always_ff @(posedge clock_bus_i) begin
		if (ram.wren) begin
			mem[ram.addr] <= ram.wdata;
		end
	end

	// registered read, old data on a same-address write
	always_ff @(posedge clock_bus_i) begin
		ram.rdata <= mem[ram.addr];
	end

endmodule

//--- verilog/data_ram_if.sv
`timescale 1ns/1ps

interface data_ram_if;
	import cache_geom_pkg::*;

	ram_addr_t addr;            // [slot|offset]
	word_t     wdata;
	logic      wren;            // write on this edge
	word_t     rdata;           // one cycle after addr

	// controller drives the ram
	modport ctrl (
		output addr,
		output wdata,
		output wren,
		input  rdata
	);

	// ram side
	modport ram (
		input  addr,
		input  wdata,
		input  wren,
		output rdata
	);

endinterface

//--- verilog/fa_cache_top.sv
`timescale 1ns/1ps

module fa_cache_top (
	input  logic                       clock_bus_i,
	input  logic                       resetn_i,
	// core
	input  logic                       req_i,
	input  logic                       rw_i,
	input  cache_geom_pkg::word_addr_t addr_i,
	input  cache_geom_pkg::word_t      wdata_i,
	output logic                       done_o,
	output logic                       hit_o,
	output cache_geom_pkg::word_t      rdata_o,
	// backing memory
	output logic                       mem_req_o,
	output logic                       mem_we_o,
	output cache_geom_pkg::word_addr_t mem_addr_o,
	output cache_geom_pkg::word_t      mem_wdata_o,
	input  logic                       mem_ack_i,
	input  cache_geom_pkg::word_t      mem_rdata_i,
	// perf readout
	input  logic [1:0]                 metric_sel_i,
	output cache_geom_pkg::count_t     count_o
);
	import cache_geom_pkg::*;
	import cache_ctrl_pkg::*;

	// ------------------------------------------------------------
	// internal wiring
	// ------------------------------------------------------------
	tag_t  lookup_tag;
	logic  cam_hit;
	slot_t cam_hit_slot;
	logic  cam_wr;
	slot_t cam_slot;                                // victim, read and write side
	tag_t  cam_wr_tag;
	tag_t  victim_tag;
	logic  flag_hit;
	logic  flag_miss;
	logic  flag_wb;

	data_ram_if ram_bus ();

	tag_cam tag_cam_inst (
		.clock_bus_i  (clock_bus_i),
		.resetn_i     (resetn_i),
		.lookup_tag_i (lookup_tag),
		.wr_en_i      (cam_wr),
		.wr_slot_i    (cam_slot),
		.wr_tag_i     (cam_wr_tag),
		.rd_slot_i    (cam_slot),
		.hit_o        (cam_hit),
		.hit_slot_o   (cam_hit_slot),
		.rd_tag_o     (victim_tag)
	);

	data_ram data_ram_inst (
		.clock_bus_i (clock_bus_i),
		.ram         (ram_bus.ram)
	);

	cache_controller cache_controller_inst (
		.clock_bus_i      (clock_bus_i),
		.resetn_i         (resetn_i),
		.req_i            (req_i),
		.rw_i             (rw_i),
		.addr_i           (addr_i),
		.wdata_i          (wdata_i),
		.done_o           (done_o),
		.hit_o            (hit_o),
		.rdata_o          (rdata_o),
		.lookup_tag_o     (lookup_tag),
		.cam_hit_i        (cam_hit),
		.cam_slot_i       (cam_hit_slot),
		.cam_wr_o         (cam_wr),
		.cam_slot_o       (cam_slot),
		.cam_tag_o        (cam_wr_tag),
		.cam_victim_tag_i (victim_tag),
		.ram              (ram_bus.ctrl),
		.mem_req_o        (mem_req_o),
		.mem_we_o         (mem_we_o),
		.mem_addr_o       (mem_addr_o),
		.mem_wdata_o      (mem_wdata_o),
		.mem_ack_i        (mem_ack_i),
		.mem_rdata_i      (mem_rdata_i),
		.flag_hit_o       (flag_hit),
		.flag_miss_o      (flag_miss),
		.flag_wb_o        (flag_wb)
	);

	perf_counters perf_counters_inst (
		.clock_bus_i  (clock_bus_i),
		.resetn_i     (resetn_i),
		.hit_i        (flag_hit),
		.miss_i       (flag_miss),
		.wb_i         (flag_wb),
		.metric_sel_i (metric_sel_t'(metric_sel_i)),  // plain bits at the pins
		.count_o      (count_o)
	);

endmodule

//--- verilog/perf_counters.sv
`timescale 1ns/1ps

module perf_counters (
	input  logic                        clock_bus_i,
	input  logic                        resetn_i,
	input  logic                        hit_i,          // one cycle flag pulses
	input  logic                        miss_i,
	input  logic                        wb_i,
	input  cache_ctrl_pkg::metric_sel_t metric_sel_i,
	output cache_geom_pkg::count_t      count_o
);
	import cache_geom_pkg::*;
	import cache_ctrl_pkg::*;

	count_t     cnt [3];                            // hits, misses, writebacks
	logic [2:0] ev;

	assign ev = {wb_i, miss_i, hit_i};

	// ------------------------------------------------------------
	// saturating counters
	// ------------------------------------------------------------
	always_ff @(posedge clock_bus_i) begin
		if (!resetn_i) begin
			for (int i = 0; i < 3; i++) begin
				cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (ev[i] && (cnt[i] != '1)) begin     // hold at all ones
					cnt[i] <= cnt[i] + count_t'(1);
				end
			end
		end
	end

	// readout mux
	always_comb begin
		case (metric_sel_i)
			hits:       count_o = cnt[0];
			misses:     count_o = cnt[1];
			writebacks: count_o = cnt[2];
			default:    count_o = '0;                 // none
		endcase
	end

endmodule

//--- verilog/tag_cam.sv
`timescale 1ns/1ps

module tag_cam (
	input  logic                  clock_bus_i,
	input  logic                  resetn_i,
	input  cache_geom_pkg::tag_t  lookup_tag_i,     // compared against every slot
	input  logic                  wr_en_i,          // load a new tag, sets valid
	input  cache_geom_pkg::slot_t wr_slot_i,
	input  cache_geom_pkg::tag_t  wr_tag_i,
	input  cache_geom_pkg::slot_t rd_slot_i,        // victim slot
	output logic                  hit_o,
	output cache_geom_pkg::slot_t hit_slot_o,       // lowest matching slot
	output cache_geom_pkg::tag_t  rd_tag_o          // tag held at rd_slot_i
);
	import cache_geom_pkg::*;

	tag_t                   tags [capacity_lp];
	logic [capacity_lp-1:0] valid;
	logic [capacity_lp-1:0] match;

	// ------------------------------------------------------------
	// storage
	// ------------------------------------------------------------
	always_ff @(posedge clock_bus_i) begin
		if (!resetn_i) begin
			valid <= '0;                            // empty cache out of reset
		end else if (wr_en_i) begin
			valid[wr_slot_i] <= 1'b1;
		end
	end

	always_ff @(posedge clock_bus_i) begin
		if (wr_en_i) begin
			tags[wr_slot_i] <= wr_tag_i;
		end
	end

	// ------------------------------------------------------------
	// parallel compare
	// ------------------------------------------------------------
	always_comb begin
		for (int i = 0; i < capacity_lp; i++) begin
			match[i] = valid[i] && (tags[i] == lookup_tag_i);
		end
	end

	assign hit_o = |match;

	// priority encode, lowest index wins
	always_comb begin
		hit_slot_o = '0;
		for (int i = capacity_lp - 1; i >= 0; i--) begin
			if (match[i]) begin
				hit_slot_o = slot_t'(i);
			end
		end
	end

	assign rd_tag_o = tags[rd_slot_i];              // write-back address source

endmodule
